// ==== logic/fetch_cfg.svh ====
// Fetch subsystem configuration
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

//////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////

`define ICACHE_LINES 32             // Direct-mapped lines, power of two

//////////////////////////////////////////////////////////////
// Memory model
//////////////////////////////////////////////////////////////

`define MEM_LATENCY  12             // Cycles from accept to data return, at least 2
`define MEM_TAGS     15             // Usable transaction tags, tag 0 means no response
`define MEM_FILL_KEY 32'h5a3c_96e1  // Word at address a reads as a ^ key

//////////////////////////////////////////////////////////////
// Fetch
//////////////////////////////////////////////////////////////

`define RESET_PC     32'h0000_0100  // First PC out of reset

`endif

// ==== logic/mem_bus_pkg.sv ====
// Memory bus definitions
package mem_bus_pkg;

    //////////////////////////////////////////////////////////////
    // Commands and transaction tags
    //////////////////////////////////////////////////////////////

    localparam int MEM_CMD_BITS = 2;   // Command field width
    localparam int MEM_TAG_BITS = 4;   // Enough for 15 live loads

    localparam logic [MEM_CMD_BITS-1:0] MEM_NONE = 2'd0;  // Idle bus
    localparam logic [MEM_CMD_BITS-1:0] MEM_LOAD = 2'd1;  // Block read

    //////////////////////////////////////////////////////////////
    // Memory block
    //////////////////////////////////////////////////////////////

    // One 64-bit block as memory and cache see it,
    // or as two instruction words as fetch sees it
    typedef union packed {
        logic [63:0]      double_word;  // Whole block
        logic [1:0][31:0] words;        // words[0] at the lower address
    } mem_block_t;

endpackage

// ==== logic/icache_pkg.sv ====
// Instruction cache address fields
`include "fetch_cfg.svh"

package icache_pkg;

    //////////////////////////////////////////////////////////////
    // Address split
    //////////////////////////////////////////////////////////////

    localparam int NUM_LINES      = `ICACHE_LINES;       // Lines in the cache
    localparam int OFFSET_BITS    = 3;                   // Byte offset in a block
    localparam int INDEX_BITS     = $clog2(NUM_LINES);   // Line select
    localparam int CACHE_ADDR_MSB = 15;                  // Top bit the cache looks at

    // Tag covers whatever lies between index and bit 15
    localparam int TAG_BITS = CACHE_ADDR_MSB - OFFSET_BITS + 1 - INDEX_BITS;

    // Address bits 15:3 hold {tag, index}
    localparam int INDEX_LSB = OFFSET_BITS;
    localparam int TAG_LSB   = OFFSET_BITS + INDEX_BITS;

endpackage

// ==== logic/dual_port_ram.sv ====
// Simple dual-port RAM
module dual_port_ram #(
    parameter int WIDTH = 64,   // Bits per entry
    parameter int DEPTH = 32    // Entries
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write_enable,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  logic [WIDTH-1:0]         write_data,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    output logic [WIDTH-1:0]         read_data
);

    //////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] mem_array [DEPTH];  // Contents survive reset

    //////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////

    // Writes are held off while reset is asserted
    always_ff @(posedge clock) begin
        if (write_enable && !reset) begin
            mem_array[write_addr] <= write_data;  // Lands at the edge
        end
    end

    //////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////

    // Asynchronous read, no bypass of a same-cycle write
    assign read_data = mem_array[read_addr];

endmodule

// ==== logic/icache_blocking.sv ====
// Blocking instruction cache
module icache_blocking import mem_bus_pkg::*; import icache_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    // Fetch side
    input  logic [31:0]             fetch_addr,
    output mem_block_t              block_data,   // Block holding fetch_addr
    output logic                    block_valid,  // Hit on the current address
    // Memory side
    output logic [MEM_CMD_BITS-1:0] mem_command,
    output logic [31:0]             mem_addr,
    input  logic [MEM_TAG_BITS-1:0] grant_tag,    // Zero unless a load was accepted
    input  mem_block_t              resp_data,
    input  logic [MEM_TAG_BITS-1:0] resp_tag      // Zero unless data is returning
);

    //////////////////////////////////////////////////////////////
    // Address fields
    //////////////////////////////////////////////////////////////

    logic [INDEX_BITS-1:0] current_index, last_index;
    logic [TAG_BITS-1:0]   current_tag,   last_tag;

    assign current_index = fetch_addr[INDEX_LSB +: INDEX_BITS];
    assign current_tag   = fetch_addr[TAG_LSB +: TAG_BITS];

    //////////////////////////////////////////////////////////////
    // Tag store and data lines
    //////////////////////////////////////////////////////////////

    logic [TAG_BITS-1:0]  line_tag [NUM_LINES];  // Meaningful only when valid
    logic [NUM_LINES-1:0] line_valid;
    logic                 line_write;            // Fill the current line

    dual_port_ram #(
        .WIDTH($bits(mem_block_t)),
        .DEPTH(NUM_LINES)
    ) u_data_ram (
        .clock       (clock),
        .reset       (reset),
        .write_enable(line_write),
        .write_addr  (current_index),
        .write_data  (resp_data),
        .read_addr   (current_index),
        .read_data   (block_data)
    );

    assign block_valid = line_valid[current_index] &&
                         (line_tag[current_index] == current_tag);

    //////////////////////////////////////////////////////////////
    // Miss tracking
    //////////////////////////////////////////////////////////////

    logic [MEM_TAG_BITS-1:0] wait_tag;          // Memory tag of the live miss
    logic                    miss_outstanding;  // Load sent but not yet granted
    logic                    changed_addr;
    logic                    got_mem_data;
    logic                    update_wait_tag;
    logic                    unanswered_miss;

    // New block requested this cycle
    assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

    assign got_mem_data = (wait_tag != '0) && (resp_tag == wait_tag);  // Our data is back
    assign line_write   = got_mem_data && !changed_addr;  // Late data for an old address is dropped

    // Grant is zero when no load is accepted, so this also clears the wait tag
    assign update_wait_tag = changed_addr || miss_outstanding || got_mem_data;

    // A fresh miss on a new address, or a load still waiting for its grant
    assign unanswered_miss = changed_addr ? !block_valid
                                          : (miss_outstanding && (grant_tag == '0));

    //////////////////////////////////////////////////////////////
    // Memory request
    //////////////////////////////////////////////////////////////

    assign mem_command = (miss_outstanding && !changed_addr) ? MEM_LOAD : MEM_NONE;
    assign mem_addr    = {fetch_addr[31:OFFSET_BITS], OFFSET_BITS'(0)};  // Block aligned

    //////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            last_index       <= '1;  // All ones so the first address counts as new
            last_tag         <= '1;
            wait_tag         <= '0;
            miss_outstanding <= 1'b0;
            line_valid       <= '0;
        end else begin
            last_index       <= current_index;
            last_tag         <= current_tag;
            miss_outstanding <= unanswered_miss;
            if (update_wait_tag) begin
                wait_tag <= grant_tag;
            end
            if (line_write) begin
                line_valid[current_index] <= 1'b1;
            end
        end
    end

    // Tags follow the fill, valid bits guard them
    always_ff @(posedge clock) begin
        if (line_write) begin
            line_tag[current_index] <= current_tag;
        end
    end

endmodule

// ==== logic/latency_memory.sv ====
// Tagged multi-cycle memory model
`include "fetch_cfg.svh"

module latency_memory import mem_bus_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [MEM_CMD_BITS-1:0] mem_command,
    input  logic [31:0]             mem_addr,
    output logic [MEM_TAG_BITS-1:0] grant_tag,   // Same cycle as the load
    output mem_block_t              resp_data,
    output logic [MEM_TAG_BITS-1:0] resp_tag     // One cycle, MEM_LATENCY after grant
);

    localparam int COUNT_BITS = $clog2(`MEM_LATENCY + 1);

    //////////////////////////////////////////////////////////////
    // Pending load table, one entry per tag
    //////////////////////////////////////////////////////////////

    logic [`MEM_TAGS:1]    entry_busy;
    logic [28:0]           entry_addr  [1:`MEM_TAGS];  // Block address, bits 31:3
    logic [COUNT_BITS-1:0] entry_count [1:`MEM_TAGS];  // Cycles left before the response
    logic [`MEM_TAGS:1]    entry_retire;                // Response goes out next cycle

    // Contents are a function of the address
    function automatic mem_block_t fill_block(input logic [28:0] block_addr);
        mem_block_t blk;
        blk.words[0] = {block_addr, 3'b000} ^ `MEM_FILL_KEY;
        blk.words[1] = {block_addr, 3'b100} ^ `MEM_FILL_KEY;
        return blk;
    endfunction

    //////////////////////////////////////////////////////////////
    // Tag grant
    //////////////////////////////////////////////////////////////

    // Lowest free nonzero tag wins
    always_comb begin
        grant_tag = '0;
        if (mem_command == MEM_LOAD) begin
            for (int t = `MEM_TAGS; t >= 1; t--) begin
                if (!entry_busy[t]) begin
                    grant_tag = MEM_TAG_BITS'(t);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Countdown and retire
    //////////////////////////////////////////////////////////////

    // Only one entry can be at 1 since loads arrive at most one per cycle
    always_comb begin
        for (int t = 1; t <= `MEM_TAGS; t++) begin
            entry_retire[t] = entry_busy[t] && (entry_count[t] == COUNT_BITS'(1));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_busy <= '0;
            resp_tag   <= '0;
        end else begin
            resp_tag <= '0;                           // Sentinel by default
            for (int t = 1; t <= `MEM_TAGS; t++) begin
                if (entry_retire[t]) begin
                    entry_busy[t] <= 1'b0;            // Tag is free again
                    resp_tag      <= MEM_TAG_BITS'(t);
                end
            end
            if (grant_tag != '0) begin
                entry_busy[grant_tag] <= 1'b1;
            end
        end
    end

    // Address, count and returned block only matter while busy
    always_ff @(posedge clock) begin
        for (int t = 1; t <= `MEM_TAGS; t++) begin
            if (entry_busy[t]) begin
                entry_count[t] <= entry_count[t] - COUNT_BITS'(1);
            end
            if (entry_retire[t]) begin
                resp_data <= fill_block(entry_addr[t]);
            end
        end
        if (grant_tag != '0) begin
            entry_addr[grant_tag]  <= mem_addr[31:3];
            entry_count[grant_tag] <= COUNT_BITS'(`MEM_LATENCY - 1);  // Retires at count 1
        end
    end

endmodule

// ==== logic/fetch_unit.sv ====
// Instruction fetch unit
`include "fetch_cfg.svh"

module fetch_unit import mem_bus_pkg::*; #(
    parameter logic [31:0] RESET_ADDR = `RESET_PC  // PC after reset
) (
    input  logic        clock,
    input  logic        reset,
    // Redirect strobe from outside
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    // Cache side
    output logic [31:0] fetch_addr,
    input  mem_block_t  block_data,
    input  logic        block_valid,   // Hit on fetch_addr
    // Delivered instruction
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    output logic        inst_valid     // One strobe per instruction
);

    //////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////

    logic [31:0] pc;
    logic [31:0] pc_next;

    // Redirect beats sequential advance
    always_comb begin
        pc_next = pc;
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (block_valid) begin
            pc_next = pc + 32'd4;  // Next word after a hit
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= pc_next;
        end
    end

    assign fetch_addr = pc;  // Cache looks up the current PC

    //////////////////////////////////////////////////////////////
    // Instruction select
    //////////////////////////////////////////////////////////////

    // PC bit 2 picks the half of the block
    assign inst    = block_data.words[pc[2]];
    assign inst_pc = pc;

    // The word under a redirect is thrown away
    assign inst_valid = block_valid && !redirect;

endmodule

// ==== logic/fetch_top.sv ====
// Instruction fetch subsystem top
module fetch_top import mem_bus_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    redirect,
    input  logic [31:0]             redirect_pc,
    output logic [31:0]             inst,
    output logic [31:0]             inst_pc,
    output logic                    inst_valid,
    // Memory handshake brought out for observation
    output logic [MEM_CMD_BITS-1:0] mem_command,
    output logic [MEM_TAG_BITS-1:0] grant_tag,
    output logic [MEM_TAG_BITS-1:0] resp_tag
);

    //////////////////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////////////////

    logic [31:0] fetch_addr;   // Fetch to cache
    mem_block_t  block_data;   // Cache to fetch
    logic        block_valid;
    logic [31:0] mem_addr;     // Cache to memory
    mem_block_t  resp_data;    // Memory to cache

    fetch_unit u_fetch_unit (
        .clock      (clock),
        .reset      (reset),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .fetch_addr (fetch_addr),
        .block_data (block_data),
        .block_valid(block_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_valid (inst_valid)
    );

    icache_blocking u_icache (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .block_data (block_data),
        .block_valid(block_valid),
        .mem_command(mem_command),
        .mem_addr   (mem_addr),
        .grant_tag  (grant_tag),
        .resp_data  (resp_data),
        .resp_tag   (resp_tag)
    );

    latency_memory u_memory (
        .clock      (clock),
        .reset      (reset),
        .mem_command(mem_command),
        .mem_addr   (mem_addr),
        .grant_tag  (grant_tag),
        .resp_data  (resp_data),
        .resp_tag   (resp_tag)
    );

endmodule

// ==== tests/fetch_props.sv ====
// Memory handshake assertions
module fetch_props import mem_bus_pkg::*; (
    input logic                    clock,
    input logic                    reset,
    input logic                    redirect,
    input logic                    inst_valid,
    input logic [MEM_CMD_BITS-1:0] mem_command,
    input logic [MEM_TAG_BITS-1:0] grant_tag,
    input logic [MEM_TAG_BITS-1:0] resp_tag
);

    int failure_count;  // Read by the testbench verdict

    initial failure_count = 0;

    //////////////////////////////////////////////////////////////
    // Handshake rules
    //////////////////////////////////////////////////////////////

    // A tag is only handed out for a load
    grant_needs_load: assert property (@(posedge clock) disable iff (reset)
        (grant_tag != '0) |-> (mem_command == MEM_LOAD))
        else begin
            $error("grant_tag %0d without a load command", grant_tag);
            failure_count++;
        end

    // No response while reset holds
    resp_quiet_in_reset: assert property (@(posedge clock)
        (reset && $past(reset)) |-> (resp_tag == '0))
        else begin
            $error("resp_tag %0d during reset", resp_tag);
            failure_count++;
        end

    // Word under a redirect is never delivered
    no_inst_on_redirect: assert property (@(posedge clock) disable iff (reset)
        redirect |-> !inst_valid)
        else begin
            $error("inst_valid high in a redirect cycle");
            failure_count++;
        end

endmodule

bind fetch_top fetch_props u_fetch_props (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .inst_valid (inst_valid),
    .mem_command(mem_command),
    .grant_tag  (grant_tag),
    .resp_tag   (resp_tag)
);

// ==== tests/fetch_checker.sv ====
// Fetch result checker
`include "fetch_cfg.svh"

module fetch_checker import mem_bus_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    // DUT inputs and outputs
    input  logic                    redirect,
    input  logic [31:0]             redirect_pc,
    input  logic [31:0]             inst,
    input  logic [31:0]             inst_pc,
    input  logic                    inst_valid,
    input  logic [MEM_CMD_BITS-1:0] mem_command,
    // Test control from the stimulus loop
    input  logic                    test_start,   // New row begins
    input  logic [127:0]            test_name,
    input  int                      test_length,  // Instructions to collect
    input  logic                    test_stream,  // One instruction every cycle
    output logic                    test_done,
    output int                      tests_passed,
    output int                      tests_failed,
    output int                      total_errors
);

    logic [31:0]  expected_pc;     // Next PC the fetch unit must deliver
    logic         reset_q;         // Reset seen at the previous edge
    logic         running;
    int           delivered;
    int           test_errors;
    logic [127:0] current_name;
    int           current_length;
    logic         current_stream;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
        total_errors = 0;
        test_errors  = 0;
        delivered    = 0;
        running      = 1'b0;
        expected_pc  = `RESET_PC;
        test_done   <= 1'b0;
        reset_q     <= 1'b0;
    end

    task automatic report_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic finish_test(input logic [127:0] name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0s: passed, %0d instructions", name, delivered);
        end else begin
            tests_failed++;
            $display("test %0s: failed, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////
    // Sampling at the rising edge
    //////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        reset_q <= reset;
        if (reset_q) begin  // DUT registers hold reset values here
            if (mem_command != MEM_NONE)
                report_error($sformatf("mem_command %0d in reset state", mem_command));
            if (inst_valid)
                report_error("inst_valid high in reset state");
            if (!reset)
                finish_test("reset_state");
        end
        if (reset) begin
            expected_pc = `RESET_PC;
        end else begin
            if (test_start) begin
                running        = 1'b1;
                delivered      = 0;
                test_errors    = 0;
                current_name   = test_name;
                current_length = test_length;
                current_stream = test_stream;
                test_done     <= 1'b0;
            end
            if (redirect) begin
                expected_pc = redirect_pc;  // Target is the next delivered PC
            end else if (inst_valid) begin
                if (inst_pc !== expected_pc)
                    report_error($sformatf("inst_pc %h, expected %h", inst_pc, expected_pc));
                if (inst !== (expected_pc ^ `MEM_FILL_KEY))
                    report_error($sformatf("inst %h at pc %h, expected %h",
                                           inst, expected_pc, expected_pc ^ `MEM_FILL_KEY));
                expected_pc = expected_pc + 32'd4;
                if (running)
                    delivered++;
            end else if (running && current_stream) begin
                report_error($sformatf("no instruction delivered at pc %h", expected_pc));
            end
            if (running && delivered >= current_length) begin
                finish_test(current_name);
                running    = 1'b0;
                test_done <= 1'b1;
            end
        end
    end

endmodule

// ==== tests/fetch_tb.sv ====
// Fetch subsystem testbench
`include "fetch_cfg.svh"

module fetch_tb import mem_bus_pkg::*; ();

    localparam int MAX_ROWS       = 8;
    localparam int TIMEOUT_MARGIN = 100;  // Reset, gaps and drain

    logic                    clock;
    logic                    reset;
    logic                    redirect;
    logic [31:0]             redirect_pc;
    logic [31:0]             inst;
    logic [31:0]             inst_pc;
    logic                    inst_valid;
    logic [MEM_CMD_BITS-1:0] mem_command;
    logic [MEM_TAG_BITS-1:0] grant_tag;
    logic [MEM_TAG_BITS-1:0] resp_tag;

    // Checker control and results
    logic         test_start;
    logic [127:0] test_name;
    int           test_length;
    logic         test_stream;
    logic         test_done;
    int           tests_passed;
    int           tests_failed;
    int           total_errors;

    //////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////

    logic [127:0] row_name     [MAX_ROWS];
    logic         row_redirect [MAX_ROWS];  // Low means carry on from reset
    logic [31:0]  row_target   [MAX_ROWS];
    int           row_length   [MAX_ROWS];  // Instructions to collect
    logic         row_stream   [MAX_ROWS];  // Whole region already cached
    int           num_rows;

    int     cycle_count;
    int     timeout_limit;
    integer seed;
    int     gap;

    task automatic add_row(input logic [127:0] name, input logic redirect_en,
                           input logic [31:0] target, input int length,
                           input logic stream);
        row_name[num_rows]     = name;
        row_redirect[num_rows] = redirect_en;
        row_target[num_rows]   = target;
        row_length[num_rows]   = length;
        row_stream[num_rows]   = stream;
        num_rows++;
    endtask

    //////////////////////////////////////////////////////////////
    // DUT, checker and clock
    //////////////////////////////////////////////////////////////

    fetch_top u_fetch_top (
        .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
        .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid),
        .mem_command(mem_command), .grant_tag(grant_tag), .resp_tag(resp_tag)
    );

    fetch_checker u_checker (
        .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
        .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid), .mem_command(mem_command),
        .test_start(test_start), .test_name(test_name), .test_length(test_length),
        .test_stream(test_stream), .test_done(test_done), .tests_passed(tests_passed),
        .tests_failed(tests_failed), .total_errors(total_errors)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;  // Period 8

    // Cycle limit scaled from the table
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: tests still waiting for instructions after %0d cycles",
                     cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        seed         = 32'hdd7c9be6;
        num_rows     = 0;
        cycle_count <= 0;
        reset       <= 1'b1;
        redirect    <= 1'b0;
        redirect_pc <= '0;
        test_start  <= 1'b0;
        test_name   <= '0;
        test_length <= 0;
        test_stream <= 1'b0;

        add_row("seq_reset",     1'b0, 32'h0000_0000, 24, 1'b0);  // Blocks 0x100 to 0x15c
        add_row("redirect_miss", 1'b1, 32'h0000_0480,  8, 1'b0);  // Drops the 0x160 miss
        add_row("loop_refetch",  1'b1, 32'h0000_0100, 16, 1'b1);  // All hits
        add_row("conflict_a0",   1'b1, 32'h0000_0600,  2, 1'b0);  // Index 0, tag 0x06
        add_row("conflict_b0",   1'b1, 32'h0000_1600,  2, 1'b0);  // Index 0, tag 0x16
        add_row("conflict_a1",   1'b1, 32'h0000_0600,  2, 1'b0);
        add_row("conflict_b1",   1'b1, 32'h0000_1600,  2, 1'b0);

        timeout_limit = TIMEOUT_MARGIN;
        for (int i = 0; i < num_rows; i++) begin
            timeout_limit += row_length[i] * (`MEM_LATENCY + 4);
        end

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < num_rows; i++) begin
            gap = $random(seed) & 3;  // Hold 0 to 3 cycles
            repeat (gap) @(posedge clock);
            test_name   <= row_name[i];
            test_length <= row_length[i];
            test_stream <= row_stream[i];
            test_start  <= 1'b1;
            if (row_redirect[i]) begin
                redirect    <= 1'b1;
                redirect_pc <= row_target[i];
            end
            @(posedge clock);
            test_start <= 1'b0;
            redirect   <= 1'b0;
            do begin
                @(posedge clock);
            end while (!test_done);
        end

        repeat (4) @(posedge clock);
        $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, total_errors,
                 u_fetch_top.u_fetch_props.failure_count);
        if (tests_failed == 0 && total_errors == 0 &&
            u_fetch_top.u_fetch_props.failure_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/mem_bus_pkg.sv
logic/icache_pkg.sv
logic/dual_port_ram.sv
logic/icache_blocking.sv
logic/latency_memory.sv
logic/fetch_unit.sv
logic/fetch_top.sv
tests/fetch_props.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module fetch_tb \
    -Mdir obj_dir -o fetch_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetch_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "^>>> PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
